// ==== logic/apple1_pkg.sv ====
//**********************************************************
// shared constants, types and video stage structs for the
// Apple 1 style video terminal, imported by every module
//**********************************************************
package apple1_pkg;

    // 640x480 at 60 Hz on a 25 MHz pixel clock
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_TOTAL   = 800;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 525;

    // text screen geometry
    localparam int COLS  = 40;
    localparam int ROWS  = 24;
    localparam int CELLS = 960;

    // 25 MHz / 115200 baud
    localparam int CLKS_PER_BIT = 217;

    // cycles from a registered beam position to the pins
    localparam int VIDEO_LATENCY = 3;

    // glyph table, one 40-bit glyph per line
    localparam string FONT_FILE = "logic/font.hex";

    typedef logic [5:0]  char_code_t;
    typedef logic [9:0]  cell_addr_t;
    typedef logic [39:0] glyph_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic {TERM_RUN, TERM_CLEARING} term_state_t;

    typedef struct packed {
        logic       h_sync;
        logic       v_sync;
        logic       visible;
        cell_addr_t addr;
        logic [2:0] glyph_col;
        logic [3:0] glyph_row;
    } beam_t;

    typedef struct packed {
        beam_t      beam;
        char_code_t code;
    } fetch_t;

    typedef struct packed {
        logic       en;
        cell_addr_t addr;
        char_code_t code;
    } screen_wr_t;

    // syncs inactive and nothing visible
    localparam beam_t BEAM_IDLE = '{h_sync: 1'b1, v_sync: 1'b1, default: '0};

endpackage

// ==== logic/uart_rx.sv ====
//**********************************************************
// 8N1 serial receiver, one byte per rx_strobe pulse
//**********************************************************
`timescale 1ns/1ns

module uart_rx (
    input  logic       clk25,
    input  logic       reset,
    input  logic       uart_rx,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);
    import apple1_pkg::*;

    logic      rx_meta;
    logic      rx_sync;
    rx_state_t state;
    logic [7:0] clk_cnt;
    logic [2:0] bit_idx;
    logic      bit_end;

    // line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk25) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // full bit period elapsed, we are mid-bit again
    assign bit_end = (clk_cnt == 8'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk25) begin
        if (reset) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            clk_cnt   <= clk_cnt + 8'd1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit in, start bit must still be low
                    if (clk_cnt == 8'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // framing error when the stop bit is low
                    if (bit_end) begin
                        rx_strobe <= rx_sync;
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first into the top of the shifter
    always_ff @(posedge clk25) begin
        if (state == RX_DATA && bit_end) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

    a_strobe_single: assert property (@(posedge clk25) disable iff (reset)
        rx_strobe |=> !rx_strobe)
        else $error("rx_strobe held longer than one cycle");

endmodule

// ==== logic/terminal_writer.sv ====
//**********************************************************
// Apple 1 terminal rules, turns received bytes into screen
// memory writes and runs the 960-cycle screen clear
//**********************************************************
`timescale 1ns/1ns

module terminal_writer (
    input  logic                   clk25,
    input  logic                   reset,
    input  logic [7:0]             rx_data,
    input  logic                   rx_strobe,
    input  logic                   clr_screen_btn,
    output apple1_pkg::screen_wr_t wr,
    output logic                   uart_cts
);
    import apple1_pkg::*;

    term_state_t state;
    cell_addr_t  clr_addr;
    logic [5:0]  cur_col;
    logic [4:0]  cur_row;
    logic [4:0]  next_row;
    cell_addr_t  cur_addr;
    logic        printable;
    logic [7:0]  folded;

    // host may only send while we are not clearing
    assign uart_cts = (state == TERM_RUN);

    // 0x20 to 0x7f
    assign printable = !rx_data[7] && (rx_data[6:5] != 2'b00);
    // lower case onto upper case
    assign folded = (rx_data >= 8'h60) ? rx_data - 8'h20 : rx_data;

    assign cur_addr = cell_addr_t'(cur_row) * cell_addr_t'(COLS) + cell_addr_t'(cur_col);
    // no scrolling, bottom row wraps to the top
    assign next_row = (cur_row == 5'(ROWS - 1)) ? 5'd0 : cur_row + 5'd1;

    always_ff @(posedge clk25) begin
        if (reset) begin
            state    <= TERM_CLEARING;
            clr_addr <= '0;
            cur_col  <= '0;
            cur_row  <= '0;
            wr.en    <= 1'b0;
        end else begin
            wr.en <= 1'b0;
            case (state)
                TERM_RUN: begin
                    if (clr_screen_btn) begin
                        state    <= TERM_CLEARING;
                        clr_addr <= '0;
                    end else if (rx_strobe) begin
                        if (rx_data == 8'h0D) begin
                            // carriage return
                            cur_col <= '0;
                            cur_row <= next_row;
                        end else if (printable) begin
                            wr.en   <= 1'b1;
                            wr.addr <= cur_addr;
                            wr.code <= folded[5:0];
                            if (cur_col == 6'(COLS - 1)) begin
                                cur_col <= '0;
                                cur_row <= next_row;
                            end else begin
                                cur_col <= cur_col + 6'd1;
                            end
                        end
                    end
                end
                TERM_CLEARING: begin
                    // one blank per cycle, strobes are dropped here
                    wr.en   <= 1'b1;
                    wr.addr <= clr_addr;
                    wr.code <= 6'd32;
                    if (clr_addr == cell_addr_t'(CELLS - 1)) begin
                        state   <= TERM_RUN;
                        cur_col <= '0;
                        cur_row <= '0;
                    end else begin
                        clr_addr <= clr_addr + cell_addr_t'(1);
                    end
                end
                default: state <= TERM_CLEARING;
            endcase
        end
    end

    a_wr_in_range: assert property (@(posedge clk25) disable iff (reset)
        wr.en |-> (wr.addr < cell_addr_t'(CELLS)))
        else $error("screen write outside the 960 cells");

endmodule

// ==== logic/vga_timing.sv ====
//**********************************************************
// video stage 1, raster counters decoded into a beam_t
//**********************************************************
`timescale 1ns/1ns

module vga_timing (
    input  logic              clk25,
    input  logic              reset,
    output apple1_pkg::beam_t beam
);
    import apple1_pkg::*;

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic [9:0] h_nxt;
    logic [9:0] v_nxt;
    // scanline inside a 20-line text row, and the text row
    logic [4:0] line_cnt;
    logic [4:0] line_nxt;
    logic [4:0] row_cnt;
    logic [4:0] row_nxt;

    // beam fields for one counter position
    function automatic beam_t make_beam(input logic [9:0] h, input logic [9:0] v,
                                        input logic [4:0] line, input logic [4:0] row);
        beam_t b;
        b.h_sync  = !((h >= 10'(H_VISIBLE + H_FRONT)) &&
                      (h < 10'(H_VISIBLE + H_FRONT + H_SYNC)));
        b.v_sync  = !((v >= 10'(V_VISIBLE + V_FRONT)) &&
                      (v < 10'(V_VISIBLE + V_FRONT + V_SYNC)));
        b.visible = (h < 10'(H_VISIBLE)) && (v < 10'(V_VISIBLE));
        // pixels doubled, so 16 clocks per text column
        b.addr    = b.visible ?
                    cell_addr_t'(row) * cell_addr_t'(COLS) + cell_addr_t'(h[9:4]) : '0;
        b.glyph_col = h[3:1];
        b.glyph_row = line[4:1];
        return b;
    endfunction

    always_comb begin
        h_nxt    = h_cnt + 10'd1;
        v_nxt    = v_cnt;
        line_nxt = line_cnt;
        row_nxt  = row_cnt;
        if (h_cnt == 10'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (v_cnt == 10'(V_TOTAL - 1)) begin
                v_nxt    = '0;
                line_nxt = '0;
                row_nxt  = '0;
            end else begin
                v_nxt = v_cnt + 10'd1;
                // ten glyph lines, each shown twice
                if (line_cnt == 5'd19) begin
                    line_nxt = '0;
                    row_nxt  = row_cnt + 5'd1;
                end else begin
                    line_nxt = line_cnt + 5'd1;
                end
            end
        end
    end

    // beam is registered alongside the counters it describes
    always_ff @(posedge clk25) begin
        if (reset) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            line_cnt <= '0;
            row_cnt  <= '0;
            beam     <= make_beam('0, '0, '0, '0);
        end else begin
            h_cnt    <= h_nxt;
            v_cnt    <= v_nxt;
            line_cnt <= line_nxt;
            row_cnt  <= row_nxt;
            beam     <= make_beam(h_nxt, v_nxt, line_nxt, row_nxt);
        end
    end

    a_h_range: assert property (@(posedge clk25) disable iff (reset)
        h_cnt < 10'(H_TOTAL))
        else $error("horizontal counter past the line end");

endmodule

// ==== logic/char_fetch.sv ====
//**********************************************************
// video stage 2, 960-cell screen memory read under the beam
// with the terminal write port on the side
//**********************************************************
`timescale 1ns/1ns

module char_fetch (
    input  logic                   clk25,
    input  logic                   reset,
    input  apple1_pkg::screen_wr_t wr,
    input  apple1_pkg::beam_t      beam,
    output apple1_pkg::fetch_t     fetch
);
    import apple1_pkg::*;

    // one character code per cell
    char_code_t screen_mem [CELLS];

    always_ff @(posedge clk25) begin
        if (wr.en) begin
            screen_mem[wr.addr] <= wr.code;
        end
    end

    // synchronous read, beam fields delayed to match
    always_ff @(posedge clk25) begin
        fetch.code <= screen_mem[beam.addr];
        if (reset) begin
            fetch.beam <= BEAM_IDLE;
        end else begin
            fetch.beam <= beam;
        end
    end

endmodule

// ==== logic/glyph_render.sv ====
//**********************************************************
// video stages 3 and 4, font lookup and pixel selection
// feeding the registered sync and pixel outputs
//**********************************************************
`timescale 1ns/1ns

module glyph_render (
    input  logic               clk25,
    input  logic               reset,
    input  apple1_pkg::fetch_t fetch,
    output logic               h_sync,
    output logic               v_sync,
    output logic               pixel
);
    import apple1_pkg::*;

    glyph_t     font_rom [64];
    glyph_t     glyph_q;
    beam_t      beam_q;
    logic       in_glyph;
    logic [5:0] bit_sel;
    logic       pix_on;

    initial begin
        $readmemh(FONT_FILE, font_rom);
    end

    // stage 3
    always_ff @(posedge clk25) begin
        glyph_q <= font_rom[fetch.code];
        if (reset) begin
            beam_q <= BEAM_IDLE;
        end else begin
            beam_q <= fetch.beam;
        end
    end

    // 5x8 glyph inside the 8x10 cell, the rest is spacing
    assign in_glyph = (beam_q.glyph_col < 3'd5) && (beam_q.glyph_row < 4'd8);

    always_comb begin
        bit_sel = '0;
        if (in_glyph) begin
            // row 0 sits in the top five bits, left pixel highest
            bit_sel = 6'd39 - (6'(beam_q.glyph_row) * 6'd5 + 6'(beam_q.glyph_col));
        end
    end

    assign pix_on = beam_q.visible && in_glyph && glyph_q[bit_sel];

    // stage 4
    always_ff @(posedge clk25) begin
        if (reset) begin
            h_sync <= 1'b1;
            v_sync <= 1'b1;
            pixel  <= 1'b0;
        end else begin
            h_sync <= beam_q.h_sync;
            v_sync <= beam_q.v_sync;
            pixel  <= pix_on;
        end
    end

endmodule

// ==== logic/apple1_terminal.sv ====
//**********************************************************
// Apple 1 video terminal top, serial in and VGA out
//**********************************************************
`timescale 1ns/1ns

module apple1_terminal (
    input  logic       clk25,
    input  logic       reset,
    input  logic       uart_rx,
    input  logic       clr_screen_btn,
    output logic       uart_cts,
    output logic       vga_h_sync,
    output logic       vga_v_sync,
    output logic [2:0] vga_r,
    output logic [2:0] vga_g,
    output logic [2:0] vga_b
);
    import apple1_pkg::*;

    logic       [7:0] rx_data;
    logic             rx_strobe;
    screen_wr_t       wr;
    beam_t            beam;
    fetch_t           fetch;
    logic             pixel;

    // serial side path into the screen memory
    uart_rx u_rx (
        .clk25(clk25), .reset(reset), .uart_rx(uart_rx),
        .rx_data(rx_data), .rx_strobe(rx_strobe)
    );

    terminal_writer u_writer (
        .clk25(clk25), .reset(reset), .rx_data(rx_data), .rx_strobe(rx_strobe),
        .clr_screen_btn(clr_screen_btn), .wr(wr), .uart_cts(uart_cts)
    );

    // video pipeline
    vga_timing u_timing (.clk25(clk25), .reset(reset), .beam(beam));

    char_fetch u_fetch (
        .clk25(clk25), .reset(reset), .wr(wr), .beam(beam), .fetch(fetch)
    );

    glyph_render u_render (
        .clk25(clk25), .reset(reset), .fetch(fetch),
        .h_sync(vga_h_sync), .v_sync(vga_v_sync), .pixel(pixel)
    );

    // monochrome bit as a slightly green white
    assign vga_r = pixel ? 3'b100 : 3'b000;
    assign vga_g = pixel ? 3'b111 : 3'b000;
    assign vga_b = pixel ? 3'b100 : 3'b000;

endmodule

// ==== tb/tb_apple1_terminal.sv ====
//**********************************************************
// testbench for the terminal top, serial text in and every
// visible pixel compared with a screen model
//**********************************************************
`timescale 1ns/1ns

module tb_apple1_terminal;
    import apple1_pkg::*;

    localparam int CELL_W       = 16;
    localparam int CELL_H       = 20;
    localparam int FRAME_CYCLES = 420000;
    localparam int FRAME_CHECKS = 5;
    localparam int BYTES_SENT   = 40 + 14 + 1000;
    // each frame check may wait a whole frame before it starts
    localparam int TIMEOUT_CYCLES = (2 * FRAME_CHECKS + 1) * FRAME_CYCLES
                                    + BYTES_SENT * (10 * CLKS_PER_BIT + 1)
                                    + 2 * (CELLS + 10);
    // counters start at 0 on reset, line 490 reaches the pins after the pipeline
    localparam int LOCK_CYCLES = (V_VISIBLE + V_FRONT) * H_TOTAL + VIDEO_LATENCY;

    logic       clk25;
    logic       reset;
    logic       uart_rx;
    logic       clr_screen_btn;
    logic       uart_cts;
    logic       vga_h_sync;
    logic       vga_v_sync;
    logic [2:0] vga_r;
    logic [2:0] vga_g;
    logic [2:0] vga_b;

    // screen model, cursor and font
    char_code_t screen [CELLS];
    glyph_t     font [64];
    int         cur_col;
    int         cur_row;

    // beam position as seen on the pins
    logic locked;
    logic prev_v_sync;
    logic want_frame;
    logic frame_active;
    int   h_pos;
    int   v_pos;
    int   frames_done;
    int   cycle_count;
    int   run_cycles;

    apple1_terminal dut (
        .clk25(clk25), .reset(reset), .uart_rx(uart_rx), .clr_screen_btn(clr_screen_btn),
        .uart_cts(uart_cts), .vga_h_sync(vga_h_sync), .vga_v_sync(vga_v_sync),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
    );

    always #5 clk25 = ~clk25;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_pixel(input string name, input int h, input int v,
                                 input char_code_t code, input logic got,
                                 input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("Error: %s at h %0d v %0d code %h got %h expected %h",
                                     name, h, v, code, got, expected));
        end
    endtask

    // white pixel, so every colour channel lights with the glyph bit
    task automatic compare_colour(input int h, input int v, input char_code_t code,
                                  input logic expected);
        compare_pixel("vga_r", h, v, code, |vga_r, expected);
        compare_pixel("vga_g", h, v, code, |vga_g, expected);
        compare_pixel("vga_b", h, v, code, |vga_b, expected);
    endtask

    task automatic compare_sync(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("Error: %s at h %0d v %0d got %h expected %h",
                                     name, h_pos, v_pos, got, expected));
        end
    endtask

    task automatic expect_cts(input logic expected);
        if (uart_cts !== expected) begin
            report_failure($sformatf("Error: uart_cts got %h expected %h", uart_cts, expected));
        end
    endtask

    // blank screen, cursor home
    function automatic void clear_model();
        for (int i = 0; i < CELLS; i++) begin
            screen[i] = 6'd32;
        end
        cur_col = 0;
        cur_row = 0;
    endfunction

    // Apple 1 rules, no scrolling
    function automatic void apply_byte(input logic [7:0] b);
        logic [7:0] c;
        if (b == 8'h0D) begin
            cur_col = 0;
            cur_row = (cur_row + 1) % ROWS;
        end else if (b >= 8'h20 && b <= 8'h7F) begin
            c = (b >= 8'h60) ? b - 8'h20 : b;
            screen[cur_row * COLS + cur_col] = c[5:0];
            if (cur_col == COLS - 1) begin
                cur_col = 0;
                cur_row = (cur_row + 1) % ROWS;
            end else begin
                cur_col = cur_col + 1;
            end
        end
    endfunction

    // expected bit at a visible position, 5x8 glyph doubled inside a 16x20 cell
    function automatic logic glyph_bit(input int h, input int v);
        char_code_t code;
        int         gc;
        int         gr;
        code = screen[(v / CELL_H) * COLS + h / CELL_W];
        gc = (h % CELL_W) / 2;
        gr = (v % CELL_H) / 2;
        if (gc >= 5 || gr >= 8) begin
            return 1'b0;
        end
        return font[code][39 - (gr * 5 + gc)];
    endfunction

    function automatic logic h_sync_level(input int h);
        return !(h >= H_VISIBLE + H_FRONT && h < H_VISIBLE + H_FRONT + H_SYNC);
    endfunction

    function automatic logic v_sync_level(input int v);
        return !(v >= V_VISIBLE + V_FRONT && v < V_VISIBLE + V_FRONT + V_SYNC);
    endfunction

    function automatic logic [7:0] random_printable(input logic lower);
        if (lower) begin
            return 8'($urandom_range(32'h7F, 32'h60));
        end else begin
            return 8'($urandom_range(32'h7F, 32'h20));
        end
    endfunction

    // 8N1, lsb first, model updated once the stop bit is out
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        @(posedge clk25);
        for (int i = 0; i < 10; i++) begin
            uart_rx <= bits[i];
            repeat (CLKS_PER_BIT) @(posedge clk25);
        end
        apply_byte(b);
    endtask

    // cts low for the 960-cycle clear, then high again
    task automatic await_clear();
        int low_cycles;
        low_cycles = 0;
        @(negedge clk25);
        expect_cts(1'b0);
        while (!uart_cts) begin
            low_cycles++;
            if (low_cycles > CELLS + 2) begin
                report_failure("uart_cts stayed low well past the 960-cycle screen clear");
            end
            @(negedge clk25);
        end
        if (low_cycles < CELLS - 2) begin
            report_failure("uart_cts came back before the screen clear could finish");
        end
        clear_model();
    endtask

    task automatic verify_next_frame();
        int target;
        target = frames_done + 1;
        want_frame = 1'b1;
        wait (frames_done == target);
    endtask

    // raster monitor, locks to the first v_sync fall at line 490
    always @(negedge clk25) begin
        if (!reset) begin
            if (locked) begin
                if (h_pos == H_TOTAL - 1) begin
                    h_pos = 0;
                    v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
                end else begin
                    h_pos = h_pos + 1;
                end
            end else if (prev_v_sync && !vga_v_sync) begin
                locked = 1'b1;
                h_pos = 0;
                v_pos = V_VISIBLE + V_FRONT;
                if (run_cycles != LOCK_CYCLES) begin
                    report_failure($sformatf(
                        "first vga_v_sync fall came %0d cycles after reset instead of %0d",
                        run_cycles, LOCK_CYCLES));
                end
            end
            prev_v_sync = vga_v_sync;
            if (locked) begin
                compare_sync("vga_h_sync", vga_h_sync, h_sync_level(h_pos));
                compare_sync("vga_v_sync", vga_v_sync, v_sync_level(v_pos));
                if (h_pos == 0 && v_pos == 0 && want_frame) begin
                    frame_active = 1'b1;
                    want_frame = 1'b0;
                end
                if (h_pos < H_VISIBLE && v_pos < V_VISIBLE) begin
                    if (frame_active) begin
                        compare_colour(h_pos, v_pos,
                                       screen[(v_pos / CELL_H) * COLS + h_pos / CELL_W],
                                       glyph_bit(h_pos, v_pos));
                    end
                end else begin
                    // blanking is always dark
                    compare_colour(h_pos, v_pos, 6'd32, 1'b0);
                end
                if (frame_active && h_pos == H_VISIBLE - 1 && v_pos == V_VISIBLE - 1) begin
                    frame_active = 1'b0;
                    frames_done = frames_done + 1;
                end
            end
            run_cycles = run_cycles + 1;
        end
    end

    always @(posedge clk25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, run still going after %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    initial begin
        clk25 = 1'b0;
        reset = 1'b1;
        uart_rx = 1'b1;
        clr_screen_btn = 1'b0;
        locked = 1'b0;
        prev_v_sync = 1'b1;
        want_frame = 1'b0;
        frame_active = 1'b0;
        h_pos = 0;
        v_pos = 0;
        frames_done = 0;
        cycle_count = 0;
        run_cycles = 0;
        void'($urandom(32'h83168a70));
        $readmemh(FONT_FILE, font);
        clear_model();

        repeat (10) @(posedge clk25);
        reset <= 1'b0;
        // reset clear, then a blank frame
        await_clear();
        verify_next_frame();

        // forty printable bytes, every fourth one lower case
        for (int i = 0; i < 40; i++) begin
            send_byte(random_printable(i % 4 == 0));
        end
        verify_next_frame();

        // text part way along a row, carriage return, then text at column 0 of the next row
        for (int i = 0; i < 5; i++) begin
            send_byte(random_printable(1'b0));
        end
        send_byte(8'h0D);
        for (int i = 0; i < 8; i++) begin
            send_byte(random_printable(1'b0));
        end
        verify_next_frame();

        // enough text to wrap past row 23 back to cell 0
        for (int i = 0; i < 1000; i++) begin
            send_byte(random_printable(i % 5 == 0));
        end
        verify_next_frame();

        // clear button pulse
        @(posedge clk25);
        clr_screen_btn <= 1'b1;
        @(posedge clk25);
        clr_screen_btn <= 1'b0;
        await_clear();
        verify_next_frame();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== logic/font.hex ====
// one Apple 1 glyph per line, codes 0 to 63 starting at @, 40 bits as 10 hex digits
// eight rows of five pixels, row 0 in the top bits, left pixel highest in each row
746F5BC1C0
7463F8C620
F463E8C7C0
74610845C0
F46318C7C0
FC21E843E0
FC21E84200
746178C5E0
8C63F8C620
71084211C0
084210C5C0
8CA98A4A20
84210843E0
8EEB58C620
8C7359C620
746318C5C0
F463E84200
74631AC9A0
F463EA4A20
7460E0C5C0
F908421080
8C6318C5C0
8C6318A880
8C635AEE20
8C54454620
8C54421080
F8444443E0
FE318C63E0
0410410400
F8C6318FE0
0008A88000
00000003E0
0000000000
2108420080
5294000000
52BEAFA940
23E8E2F880
C644444C60
64A88AC9A0
2110000000
1110841040
4104211100
012AEA9000
0109F21000
0000021100
0001F00000
0000000080
0044444000
74675CC5C0
23084211C0
74422223E0
F88820C5C0
11952F8840
FC3C10C5C0
3221E8C5C0
F844442100
7462E8C5C0
7462F08980
0008001000
0008001100
1111041040
003E0F8000
4104111100
7442220080

// ==== all.f ====
logic/apple1_pkg.sv
logic/uart_rx.sv
logic/terminal_writer.sv
logic/vga_timing.sv
logic/char_fetch.sv
logic/glyph_render.sv
logic/apple1_terminal.sv
tb/tb_apple1_terminal.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert --timescale 1ns/1ns -Wno-fatal -f all.f \
    --top-module tb_apple1_terminal -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Simulation passed$" &&
echo "PASS" || { echo "FAIL"; exit 1; }
